// ==== files.f ====
lsu_pkg.sv
lsu_wb_router.sv
vgpr_file.sv
sgpr_file.sv
lsu_retire_unit.sv
lsu_wb_top.sv
lsu_wb_tb.sv

// ==== lsu_pkg.sv ====
// Shared widths and encodings for the writeback path; register-file depths must be powers of two
`default_nettype none

package lsu_pkg;

  // Register dword and the burst one response can write
  localparam int DWORD_W       = 32;
  localparam int DWORDS_PER_OP = 4;

  // Destination/source address field as carried by the response
  localparam int ADDR_W      = 12;
  localparam int SGPR_ADDR_W = 9;
  localparam int VGPR_ADDR_W = 10;

  // Wavefront tag is the wfid with the write-back flag in bit 0
  localparam int WFID_W  = 6;
  localparam int WFTAG_W = WFID_W + 1;

  localparam int PC_W = 32;

  // Register-file select in address bits 11:10
  localparam logic [1:0] SEL_VGPR = 2'b10;
  localparam logic [1:0] SEL_SGPR = 2'b11;

  typedef enum logic [1:0] {
    wb_dest_none,
    wb_dest_vgpr,
    wb_dest_sgpr
  } wb_dest_t;

  // Index width for n entries, at least one bit
  function automatic int idx_w(input int n);
    int w;
    w = 1;
    while ((1 << w) < n) begin
      w = w + 1;
    end
    return w;
  endfunction

  // Bits of one lane's slice of the response data
  localparam int LANE_DATA_W = DWORDS_PER_OP * DWORD_W;

endpackage

`default_nettype wire

// ==== lsu_retire_unit.sv ====
// One-cycle retire stage; wfids at or above NUM_WF are not counted and read back as zero
`default_nettype none

module lsu_retire_unit #(
  parameter int NUM_WF = 64
) (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           instr_done,
  input  wire [lsu_pkg::WFID_W-1:0]     instr_done_wfid,
  input  wire [lsu_pkg::PC_W-1:0]       retire_pc,
  input  wire                           gm_or_lds,
  input  wire                           rfa_dest_wr_req,
  input  wire [lsu_pkg::WFID_W-1:0]     retire_wfid,

  output logic                          out_instr_done,
  output logic [lsu_pkg::WFID_W-1:0]    out_instr_done_wfid,
  output logic [lsu_pkg::PC_W-1:0]      out_tracemon_retire_pc,
  output logic                          out_gm_or_lds,
  output logic                          out_rfa_dest_wr_req,
  output logic [7:0]                    retire_count
);

  import lsu_pkg::*;

  logic [7:0] count_q [NUM_WF];

  // Pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      out_instr_done      <= 1'b0;
      out_rfa_dest_wr_req <= 1'b0;
    end else begin
      out_instr_done      <= instr_done;
      out_rfa_dest_wr_req <= rfa_dest_wr_req;
    end
  end

  // Retire fields hold the last retired instruction
  always_ff @(posedge clk) begin
    if (instr_done) begin
      out_instr_done_wfid    <= instr_done_wfid;
      out_tracemon_retire_pc <= retire_pc;
      out_gm_or_lds          <= gm_or_lds;
    end
  end

  // Per-wavefront counters, wrap at 256
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WF; w++) begin
      if (reset) begin
        count_q[w] <= '0;
      end else if (instr_done && instr_done_wfid == WFID_W'(w)) begin
        count_q[w] <= count_q[w] + 8'd1;
      end
    end
  end

  always_comb begin
    retire_count = '0;
    for (int w = 0; w < NUM_WF; w++) begin
      if (retire_wfid == WFID_W'(w)) begin
        retire_count = count_q[w];
      end
    end
  end

endmodule

`default_nettype wire

// ==== lsu_wb_router.sv ====
// Purely combinational decode; only address codes 10 and 11 select a file, every other code is idle
`default_nettype none

module lsu_wb_router #(
  parameter int NUM_LANES = 4
) (
  input  wire                                      in_ack,
  input  wire [NUM_LANES*lsu_pkg::LANE_DATA_W-1:0] in_rd_data,
  input  wire [lsu_pkg::WFTAG_W-1:0]               in_wftag_resp,
  input  wire [NUM_LANES-1:0]                      in_exec_value,
  input  wire [lsu_pkg::ADDR_W-1:0]                in_lddst_stsrc_addr,
  input  wire [lsu_pkg::DWORDS_PER_OP-1:0]         in_reg_wr_en,
  input  wire [lsu_pkg::PC_W-1:0]                  in_instr_pc,
  input  wire                                      in_gm_or_lds,

  output logic [lsu_pkg::SGPR_ADDR_W-1:0]          sgpr_dest_addr,
  output logic [lsu_pkg::LANE_DATA_W-1:0]          sgpr_dest_data,
  output logic [lsu_pkg::DWORDS_PER_OP-1:0]        sgpr_dest_wr_en,

  output logic [lsu_pkg::VGPR_ADDR_W-1:0]          vgpr_dest_addr,
  output logic [NUM_LANES*lsu_pkg::LANE_DATA_W-1:0] vgpr_dest_data,
  output logic [lsu_pkg::DWORDS_PER_OP-1:0]        vgpr_dest_wr_en,
  output logic [NUM_LANES-1:0]                     vgpr_dest_wr_mask,

  output logic                                     instr_done,
  output logic [lsu_pkg::WFID_W-1:0]               instr_done_wfid,
  output logic [lsu_pkg::PC_W-1:0]                 retire_pc,
  output logic                                     gm_or_lds,
  output logic                                     rfa_dest_wr_req
);

  import lsu_pkg::*;

  wb_dest_t   dest;
  logic [1:0] sel;
  logic       wb_en;

  assign sel   = in_lddst_stsrc_addr[ADDR_W-1 -: 2];
  assign wb_en = in_wftag_resp[0];

  always_comb begin
    dest = wb_dest_none;
    if (in_ack) begin
      case (sel)
        SEL_VGPR: dest = wb_dest_vgpr;
        SEL_SGPR: dest = wb_dest_sgpr;
        default:  dest = wb_dest_none;
      endcase
    end
  end

  // Write enables only when the tag asks for write-back
  always_comb begin
    vgpr_dest_wr_en = '0;
    sgpr_dest_wr_en = '0;
    if (wb_en) begin
      if (dest == wb_dest_vgpr) begin
        vgpr_dest_wr_en = in_reg_wr_en;
      end
      if (dest == wb_dest_sgpr) begin
        sgpr_dest_wr_en = in_reg_wr_en;
      end
    end
  end

  // Field slices go through untouched
  assign sgpr_dest_addr    = in_lddst_stsrc_addr[SGPR_ADDR_W-1:0];
  assign sgpr_dest_data    = in_rd_data[LANE_DATA_W-1:0];
  assign vgpr_dest_addr    = in_lddst_stsrc_addr[VGPR_ADDR_W-1:0];
  assign vgpr_dest_data    = in_rd_data;
  assign vgpr_dest_wr_mask = in_exec_value;

  // Done even when nothing is written back
  assign instr_done      = (dest != wb_dest_none);
  assign instr_done_wfid = in_wftag_resp[WFTAG_W-1:1];
  assign retire_pc       = in_instr_pc;
  assign gm_or_lds       = in_gm_or_lds;
  assign rfa_dest_wr_req = (|vgpr_dest_wr_en) | (|sgpr_dest_wr_en);

endmodule

`default_nettype wire

// ==== lsu_wb_tb.sv ====
// Directed and random checks of lsu_wb_top; reads only cover entries the model has written
`default_nettype none

module lsu_wb_tb;

  import lsu_pkg::*;

  localparam int NUM_LANES  = 4;
  localparam int VGPR_DEPTH = 64;
  localparam int SGPR_DEPTH = 128;
  localparam int NUM_WF     = 64;
  localparam int DATA_W     = NUM_LANES * LANE_DATA_W;
  localparam int LANE_W     = idx_w(NUM_LANES);
  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    logic              done;
    logic              req;
    logic [WFID_W-1:0] wfid;
    logic [PC_W-1:0]   pc;
    logic              gm;
  } retire_t;

  logic                     clk;
  logic                     reset;
  logic                     in_ack;
  logic [DATA_W-1:0]        in_rd_data;
  logic [WFTAG_W-1:0]       in_wftag_resp;
  logic [NUM_LANES-1:0]     in_exec_value;
  logic [ADDR_W-1:0]        in_lddst_stsrc_addr;
  logic [DWORDS_PER_OP-1:0] in_reg_wr_en;
  logic [PC_W-1:0]          in_instr_pc;
  logic                     in_gm_or_lds;
  logic [VGPR_ADDR_W-1:0]   vgpr_rd_addr;
  logic [LANE_W-1:0]        vgpr_rd_lane;
  logic [SGPR_ADDR_W-1:0]   sgpr_rd_addr;
  logic [WFID_W-1:0]        retire_wfid;
  logic [DWORD_W-1:0]       vgpr_rd_data;
  logic [DWORD_W-1:0]       sgpr_rd_data;
  logic                     out_instr_done;
  logic [WFID_W-1:0]        out_instr_done_wfid;
  logic [PC_W-1:0]          out_tracemon_retire_pc;
  logic                     out_gm_or_lds;
  logic                     out_rfa_dest_wr_req;
  logic [7:0]               retire_count;

  // Shadow state of both files and the retire counters
  logic [DWORD_W-1:0] vgpr_model [NUM_LANES][VGPR_DEPTH];
  logic               vgpr_known [NUM_LANES][VGPR_DEPTH];
  logic [DWORD_W-1:0] sgpr_model [SGPR_DEPTH];
  logic               sgpr_known [SGPR_DEPTH];
  logic [7:0]         count_model [NUM_WF];
  retire_t            exp_q [$];
  logic [31:0]        rng;
  int                 cycle_count = 0;

  lsu_wb_top #(
    .NUM_LANES(NUM_LANES), .VGPR_DEPTH(VGPR_DEPTH), .SGPR_DEPTH(SGPR_DEPTH), .NUM_WF(NUM_WF)
  ) dut (
    .clk(clk), .reset(reset), .in_ack(in_ack), .in_rd_data(in_rd_data),
    .in_wftag_resp(in_wftag_resp), .in_exec_value(in_exec_value),
    .in_lddst_stsrc_addr(in_lddst_stsrc_addr), .in_reg_wr_en(in_reg_wr_en),
    .in_instr_pc(in_instr_pc), .in_gm_or_lds(in_gm_or_lds),
    .vgpr_rd_addr(vgpr_rd_addr), .vgpr_rd_lane(vgpr_rd_lane), .sgpr_rd_addr(sgpr_rd_addr),
    .retire_wfid(retire_wfid), .vgpr_rd_data(vgpr_rd_data), .sgpr_rd_data(sgpr_rd_data),
    .out_instr_done(out_instr_done), .out_instr_done_wfid(out_instr_done_wfid),
    .out_tracemon_retire_pc(out_tracemon_retire_pc), .out_gm_or_lds(out_gm_or_lds),
    .out_rfa_dest_wr_req(out_rfa_dest_wr_req), .retire_count(retire_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [DATA_W-1:0] pattern_data(input logic [31:0] base);
    logic [DATA_W-1:0] d;
    d = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int i = 0; i < DWORDS_PER_OP; i++) begin
        d[(l*DWORDS_PER_OP + i)*DWORD_W +: DWORD_W] = base + 32'(l*16 + i);
      end
    end
    return d;
  endfunction

  // Bits 11:10 pick the file, 10 for vector and 11 for scalar
  function automatic wb_dest_t expected_dest(input logic ack, input logic [ADDR_W-1:0] addr);
    if (!ack) return wb_dest_none;
    if (addr[11:10] == 2'b10) return wb_dest_vgpr;
    if (addr[11:10] == 2'b11) return wb_dest_sgpr;
    return wb_dest_none;
  endfunction

  task automatic check_dword(input string what, input logic [DWORD_W-1:0] got,
                             input logic [DWORD_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s read %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input logic [WFID_W-1:0] wfid, input logic [7:0] got,
                             input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: retire count of wf %0d is %0d, expected %0d",
                          $time, wfid, got, exp));
    end
  endtask

  task automatic check_retire(input retire_t exp);
    retire_t got;
    got = {out_instr_done, out_rfa_dest_wr_req, out_instr_done_wfid,
           out_tracemon_retire_pc, out_gm_or_lds};
    if (got.done !== exp.done || got.req !== exp.req) begin
      abort_run($sformatf("mismatch at time %0t: done/request %b/%b, expected %b/%b",
                          $time, got.done, got.req, exp.done, exp.req));
    end else if (exp.done && (got.wfid !== exp.wfid || got.pc !== exp.pc || got.gm !== exp.gm)) begin
      abort_run($sformatf("mismatch at time %0t: wfid/pc/gm %0d/%h/%b, expected %0d/%h/%b",
                          $time, got.wfid, got.pc, got.gm, exp.wfid, exp.pc, exp.gm));
    end
  endtask

  // One ack cycle; the model moves to the state after the sampling edge
  task automatic send_resp(input logic ack, input logic [WFTAG_W-1:0] tag,
                           input logic [NUM_LANES-1:0] exec, input logic [ADDR_W-1:0] addr,
                           input logic [DWORDS_PER_OP-1:0] wr_en, input logic [PC_W-1:0] pc,
                           input logic gm, input logic [DATA_W-1:0] data);
    wb_dest_t dest;
    retire_t  exp;
    int       idx;
    @(posedge clk);
    in_ack              <= ack;
    in_wftag_resp       <= tag;
    in_exec_value       <= exec;
    in_lddst_stsrc_addr <= addr;
    in_reg_wr_en        <= wr_en;
    in_instr_pc         <= pc;
    in_gm_or_lds        <= gm;
    in_rd_data          <= data;
    dest     = expected_dest(ack, addr);
    exp.done = (dest != wb_dest_none);
    exp.req  = exp.done && tag[0] && (wr_en != '0);
    exp.wfid = tag[WFTAG_W-1:1];
    exp.pc   = pc;
    exp.gm   = gm;
    exp_q.push_back(exp);
    if (exp.done) begin
      count_model[exp.wfid] = count_model[exp.wfid] + 8'd1;
    end
    for (int i = 0; i < DWORDS_PER_OP; i++) begin
      if (tag[0] && wr_en[i] && dest == wb_dest_sgpr) begin
        idx = (int'(addr[SGPR_ADDR_W-1:0]) + i) % SGPR_DEPTH;
        sgpr_model[idx] = data[i*DWORD_W +: DWORD_W];
        sgpr_known[idx] = 1'b1;
      end
      if (tag[0] && wr_en[i] && dest == wb_dest_vgpr) begin
        idx = (int'(addr[VGPR_ADDR_W-1:0]) + i) % VGPR_DEPTH;
        for (int l = 0; l < NUM_LANES; l++) begin
          if (exec[l]) begin
            vgpr_model[l][idx] = data[(l*DWORDS_PER_OP + i)*DWORD_W +: DWORD_W];
            vgpr_known[l][idx] = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic finish_resp();
    @(posedge clk);
    in_ack <= 1'b0;
    @(negedge clk);
    check_retire(exp_q.pop_front());
  endtask

  // Reads go through an aliased address, high bits must be ignored
  task automatic read_vgpr(input int lane, input int idx);
    @(posedge clk);
    vgpr_rd_lane <= LANE_W'(lane);
    vgpr_rd_addr <= VGPR_ADDR_W'(idx + VGPR_DEPTH * lane);
    @(negedge clk);
    check_dword($sformatf("vgpr lane %0d entry %0d", lane, idx), vgpr_rd_data,
                vgpr_model[lane][idx]);
  endtask

  task automatic read_sgpr(input int idx);
    @(posedge clk);
    sgpr_rd_addr <= SGPR_ADDR_W'(idx + SGPR_DEPTH * (idx % 4));
    @(negedge clk);
    check_dword($sformatf("sgpr entry %0d", idx), sgpr_rd_data, sgpr_model[idx]);
  endtask

  task automatic read_count(input int wfid);
    @(posedge clk);
    retire_wfid <= WFID_W'(wfid);
    @(negedge clk);
    check_count(WFID_W'(wfid), retire_count, count_model[wfid]);
  endtask

  task automatic reread_all();
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int a = 0; a < VGPR_DEPTH; a++) begin
        if (vgpr_known[l][a]) read_vgpr(l, a);
      end
    end
    for (int a = 0; a < SGPR_DEPTH; a++) begin
      if (sgpr_known[a]) read_sgpr(a);
    end
  endtask

  // Entry 62 onward, so the burst wraps to 0 and 1
  task automatic test_vgpr_write();
    send_resp(1'b1, {6'd3, 1'b1}, 4'hF, 12'hBFE, 4'hF, 32'h0000_1000, 1'b0,
              pattern_data(32'hA000_0000));
    finish_resp();
    send_resp(1'b1, {6'd3, 1'b1}, 4'b0101, 12'hBFE, 4'b1010, 32'h0000_1004, 1'b1,
              pattern_data(32'hB000_0000));
    finish_resp();
    reread_all();
    read_count(3);
  endtask

  task automatic test_sgpr_write();
    send_resp(1'b1, {6'd4, 1'b1}, 4'h0, 12'hD7E, 4'hF, 32'h0000_2000, 1'b0,
              pattern_data(32'hC000_0000));
    finish_resp();
    send_resp(1'b1, {6'd4, 1'b1}, 4'hF, 12'hD7E, 4'b0110, 32'h0000_2004, 1'b1,
              pattern_data(32'hD000_0000));
    finish_resp();
    reread_all();
    read_count(4);
  endtask

  task automatic test_idle();
    send_resp(1'b0, {6'd7, 1'b1}, 4'hF, 12'hBFE, 4'hF, 32'h0000_3000, 1'b0,
              pattern_data(32'hE000_0000));
    finish_resp();
    send_resp(1'b1, {6'd7, 1'b1}, 4'hF, 12'h3FE, 4'hF, 32'h0000_3004, 1'b0,
              pattern_data(32'hE100_0000));
    finish_resp();
    send_resp(1'b1, {6'd7, 1'b1}, 4'hF, 12'h57E, 4'hF, 32'h0000_3008, 1'b1,
              pattern_data(32'hE200_0000));
    finish_resp();
    reread_all();
    read_count(7);
  endtask

  task automatic test_no_writeback();
    send_resp(1'b1, {6'd9, 1'b0}, 4'hF, 12'hBFE, 4'hF, 32'h0000_4000, 1'b0,
              pattern_data(32'hF000_0000));
    finish_resp();
    send_resp(1'b1, {6'd9, 1'b0}, 4'hF, 12'hD7E, 4'hF, 32'h0000_4004, 1'b1,
              pattern_data(32'hF100_0000));
    finish_resp();
    reread_all();
    read_count(9);
  endtask

  // Outputs seen at each negedge belong to the response one cycle older
  task automatic test_random_stream();
    logic [31:0]       r;
    logic [31:0]       pc;
    logic [DATA_W-1:0] data;
    for (int k = 0; k < 300; k++) begin
      rng = xorshift32(rng);
      r = rng;
      rng = xorshift32(rng);
      pc = rng;
      for (int j = 0; j < NUM_LANES * DWORDS_PER_OP; j++) begin
        rng = xorshift32(rng);
        data[j*DWORD_W +: DWORD_W] = rng;
      end
      send_resp(1'b1, r[18:12], r[22:19], r[11:0], r[26:23], pc, r[27], data);
      @(negedge clk);
      if (k > 0) check_retire(exp_q.pop_front());
    end
    finish_resp();
    reread_all();
    for (int w = 0; w < NUM_WF; w++) begin
      read_count(w);
    end
  endtask

  initial begin
    reset               = 1'b1;
    in_ack              = 1'b0;
    in_rd_data          = '0;
    in_wftag_resp       = '0;
    in_exec_value       = '0;
    in_lddst_stsrc_addr = '0;
    in_reg_wr_en        = '0;
    in_instr_pc         = '0;
    in_gm_or_lds        = 1'b0;
    vgpr_rd_addr        = '0;
    vgpr_rd_lane        = '0;
    sgpr_rd_addr        = '0;
    retire_wfid         = '0;
    rng                 = 32'h5d2;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int a = 0; a < VGPR_DEPTH; a++) vgpr_known[l][a] = 1'b0;
    end
    for (int a = 0; a < SGPR_DEPTH; a++) sgpr_known[a] = 1'b0;
    for (int w = 0; w < NUM_WF; w++) count_model[w] = 8'd0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_vgpr_write();
    test_sgpr_write();
    test_idle();
    test_no_writeback();
    test_random_stream();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsu_wb_top.sv ====
// Writeback top; no back-pressure, one response per cycle, register-file arbiter lives outside
`default_nettype none

module lsu_wb_top #(
  parameter int NUM_LANES  = 4,
  parameter int VGPR_DEPTH = 64,
  parameter int SGPR_DEPTH = 128,
  parameter int NUM_WF     = 64
) (
  input  wire                                      clk,
  input  wire                                      reset,

  input  wire                                      in_ack,
  input  wire [NUM_LANES*lsu_pkg::LANE_DATA_W-1:0] in_rd_data,
  input  wire [lsu_pkg::WFTAG_W-1:0]               in_wftag_resp,
  input  wire [NUM_LANES-1:0]                      in_exec_value,
  input  wire [lsu_pkg::ADDR_W-1:0]                in_lddst_stsrc_addr,
  input  wire [lsu_pkg::DWORDS_PER_OP-1:0]         in_reg_wr_en,
  input  wire [lsu_pkg::PC_W-1:0]                  in_instr_pc,
  input  wire                                      in_gm_or_lds,

  input  wire [lsu_pkg::VGPR_ADDR_W-1:0]           vgpr_rd_addr,
  input  wire [lsu_pkg::idx_w(NUM_LANES)-1:0]      vgpr_rd_lane,
  input  wire [lsu_pkg::SGPR_ADDR_W-1:0]           sgpr_rd_addr,
  input  wire [lsu_pkg::WFID_W-1:0]                retire_wfid,

  output logic [lsu_pkg::DWORD_W-1:0]              vgpr_rd_data,
  output logic [lsu_pkg::DWORD_W-1:0]              sgpr_rd_data,
  output logic                                     out_instr_done,
  output logic [lsu_pkg::WFID_W-1:0]               out_instr_done_wfid,
  output logic [lsu_pkg::PC_W-1:0]                 out_tracemon_retire_pc,
  output logic                                     out_gm_or_lds,
  output logic                                     out_rfa_dest_wr_req,
  output logic [7:0]                               retire_count
);

  import lsu_pkg::*;

  logic [SGPR_ADDR_W-1:0]             sgpr_dest_addr;
  logic [LANE_DATA_W-1:0]             sgpr_dest_data;
  logic [DWORDS_PER_OP-1:0]           sgpr_dest_wr_en;
  logic [VGPR_ADDR_W-1:0]             vgpr_dest_addr;
  logic [NUM_LANES*LANE_DATA_W-1:0]   vgpr_dest_data;
  logic [DWORDS_PER_OP-1:0]           vgpr_dest_wr_en;
  logic [NUM_LANES-1:0]               vgpr_dest_wr_mask;
  logic                               instr_done;
  logic [WFID_W-1:0]                  instr_done_wfid;
  logic [PC_W-1:0]                    retire_pc;
  logic                               gm_or_lds;
  logic                               rfa_dest_wr_req;

  lsu_wb_router #(.NUM_LANES(NUM_LANES)) u_router (
    .in_ack              (in_ack),
    .in_rd_data          (in_rd_data),
    .in_wftag_resp       (in_wftag_resp),
    .in_exec_value       (in_exec_value),
    .in_lddst_stsrc_addr (in_lddst_stsrc_addr),
    .in_reg_wr_en        (in_reg_wr_en),
    .in_instr_pc         (in_instr_pc),
    .in_gm_or_lds        (in_gm_or_lds),
    .sgpr_dest_addr      (sgpr_dest_addr),
    .sgpr_dest_data      (sgpr_dest_data),
    .sgpr_dest_wr_en     (sgpr_dest_wr_en),
    .vgpr_dest_addr      (vgpr_dest_addr),
    .vgpr_dest_data      (vgpr_dest_data),
    .vgpr_dest_wr_en     (vgpr_dest_wr_en),
    .vgpr_dest_wr_mask   (vgpr_dest_wr_mask),
    .instr_done          (instr_done),
    .instr_done_wfid     (instr_done_wfid),
    .retire_pc           (retire_pc),
    .gm_or_lds           (gm_or_lds),
    .rfa_dest_wr_req     (rfa_dest_wr_req)
  );

  vgpr_file #(.NUM_LANES(NUM_LANES), .VGPR_DEPTH(VGPR_DEPTH)) u_vgpr (
    .clk               (clk),
    .vgpr_dest_addr    (vgpr_dest_addr),
    .vgpr_dest_data    (vgpr_dest_data),
    .vgpr_dest_wr_en   (vgpr_dest_wr_en),
    .vgpr_dest_wr_mask (vgpr_dest_wr_mask),
    .vgpr_rd_addr      (vgpr_rd_addr),
    .vgpr_rd_lane      (vgpr_rd_lane),
    .vgpr_rd_data      (vgpr_rd_data)
  );

  sgpr_file #(.SGPR_DEPTH(SGPR_DEPTH)) u_sgpr (
    .clk             (clk),
    .sgpr_dest_addr  (sgpr_dest_addr),
    .sgpr_dest_data  (sgpr_dest_data),
    .sgpr_dest_wr_en (sgpr_dest_wr_en),
    .sgpr_rd_addr    (sgpr_rd_addr),
    .sgpr_rd_data    (sgpr_rd_data)
  );

  lsu_retire_unit #(.NUM_WF(NUM_WF)) u_retire (
    .clk                    (clk),
    .reset                  (reset),
    .instr_done             (instr_done),
    .instr_done_wfid        (instr_done_wfid),
    .retire_pc              (retire_pc),
    .gm_or_lds              (gm_or_lds),
    .rfa_dest_wr_req        (rfa_dest_wr_req),
    .retire_wfid            (retire_wfid),
    .out_instr_done         (out_instr_done),
    .out_instr_done_wfid    (out_instr_done_wfid),
    .out_tracemon_retire_pc (out_tracemon_retire_pc),
    .out_gm_or_lds          (out_gm_or_lds),
    .out_rfa_dest_wr_req    (out_rfa_dest_wr_req),
    .retire_count           (retire_count)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the writeback testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module lsu_wb_tb -f files.f -o lsu_wb_sim

# The simulator exits nonzero on a failed check; the log decides the result
./obj_dir/lsu_wb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without a failure"
exit 0

// ==== sgpr_file.sv ====
// SGPR_DEPTH entries indexed by low address bits; higher bits alias and contents are not reset
`default_nettype none

module sgpr_file #(
  parameter int SGPR_DEPTH = 128
) (
  input  wire                                 clk,
  input  wire [lsu_pkg::SGPR_ADDR_W-1:0]      sgpr_dest_addr,
  input  wire [lsu_pkg::LANE_DATA_W-1:0]      sgpr_dest_data,
  input  wire [lsu_pkg::DWORDS_PER_OP-1:0]    sgpr_dest_wr_en,
  input  wire [lsu_pkg::SGPR_ADDR_W-1:0]      sgpr_rd_addr,
  output logic [lsu_pkg::DWORD_W-1:0]        sgpr_rd_data
);

  import lsu_pkg::*;

  localparam int IDX_W = idx_w(SGPR_DEPTH);

  logic [DWORD_W-1:0] mem [SGPR_DEPTH];
  logic [IDX_W-1:0]   wr_idx [DWORDS_PER_OP];

  always_comb begin
    for (int i = 0; i < DWORDS_PER_OP; i++) begin
      wr_idx[i] = sgpr_dest_addr[IDX_W-1:0] + IDX_W'(i);
    end
  end

  // Dword i of the burst lands at base + i
  always_ff @(posedge clk) begin
    for (int i = 0; i < DWORDS_PER_OP; i++) begin
      if (sgpr_dest_wr_en[i]) begin
        mem[wr_idx[i]] <= sgpr_dest_data[i*DWORD_W +: DWORD_W];
      end
    end
  end

  assign sgpr_rd_data = mem[sgpr_rd_addr[IDX_W-1:0]];

endmodule

`default_nettype wire

// ==== vgpr_file.sv ====
// Holds VGPR_DEPTH entries per lane indexed by low address bits; higher bits alias, contents not reset
`default_nettype none

module vgpr_file #(
  parameter int NUM_LANES  = 4,
  parameter int VGPR_DEPTH = 64
) (
  input  wire                                        clk,
  input  wire [lsu_pkg::VGPR_ADDR_W-1:0]             vgpr_dest_addr,
  input  wire [NUM_LANES*lsu_pkg::LANE_DATA_W-1:0]   vgpr_dest_data,
  input  wire [lsu_pkg::DWORDS_PER_OP-1:0]           vgpr_dest_wr_en,
  input  wire [NUM_LANES-1:0]                        vgpr_dest_wr_mask,
  input  wire [lsu_pkg::VGPR_ADDR_W-1:0]             vgpr_rd_addr,
  input  wire [lsu_pkg::idx_w(NUM_LANES)-1:0]        vgpr_rd_lane,
  output logic [lsu_pkg::DWORD_W-1:0]                vgpr_rd_data
);

  import lsu_pkg::*;

  localparam int IDX_W = idx_w(VGPR_DEPTH);

  logic [DWORD_W-1:0] mem [NUM_LANES][VGPR_DEPTH];
  logic [IDX_W-1:0]   wr_idx [DWORDS_PER_OP];
  logic [IDX_W-1:0]   rd_idx;

  // Consecutive dword slots, wrapping inside the file
  always_comb begin
    for (int i = 0; i < DWORDS_PER_OP; i++) begin
      wr_idx[i] = vgpr_dest_addr[IDX_W-1:0] + IDX_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int i = 0; i < DWORDS_PER_OP; i++) begin
        if (vgpr_dest_wr_mask[l] && vgpr_dest_wr_en[i]) begin
          mem[l][wr_idx[i]] <= vgpr_dest_data[(l*DWORDS_PER_OP + i)*DWORD_W +: DWORD_W];
        end
      end
    end
  end

  assign rd_idx = vgpr_rd_addr[IDX_W-1:0];

  // Lane select beyond NUM_LANES reads zero
  always_comb begin
    vgpr_rd_data = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (vgpr_rd_lane == idx_w(NUM_LANES)'(l)) begin
        vgpr_rd_data = mem[l][rd_idx];
      end
    end
  end

endmodule

`default_nettype wire
